//--- hw/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// datapath and register index widths
`define XLEN        32
`define REG_ADDR_W  5
`define RESET_PC    32'h0000_0000   // first fetch after reset

// major opcodes of the supported subset
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LUI     7'b0110111
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_BRANCH  7'b1100011
`define OPC_JAL     7'b1101111

// funct3 values, shared by the alu and memory groups
`define F3_ADD      3'b000
`define F3_SLT      3'b010
`define F3_XOR      3'b100
`define F3_OR       3'b110
`define F3_AND      3'b111
`define F3_WORD     3'b010          // lw / sw
`define F3_BEQ      3'b000
`define F3_BNE      3'b001

`endif

//--- hw/core_pkg.sv
`include "core_defs.svh"

package core_pkg;

    // instruction formats, msb first as in the isa manual
    typedef struct packed {
        logic [6:0]             funct7;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]            imm;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]             imm_hi;  // imm[11:5]
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [4:0]             imm_lo;  // imm[4:0]
        logic [6:0]             opcode;
    } s_fmt_t;

    typedef struct packed {
        logic                   imm12;
        logic [5:0]             imm10_5;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [3:0]             imm4_1;
        logic                   imm11;
        logic [6:0]             opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]            imm;     // upper 20 bits
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } u_fmt_t;

    typedef struct packed {
        logic                   imm20;
        logic [9:0]             imm10_1;
        logic                   imm11;
        logic [7:0]             imm19_12;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } j_fmt_t;

    // one word, six views
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } instr_u;

    typedef enum logic [2:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt, alu_pass_b
    } alu_op_e;

    typedef enum logic [1:0] {
        wb_alu, wb_load, wb_pc_plus4
    } wb_sel_e;

    typedef enum logic [1:0] {
        br_none, br_beq, br_bne, br_jal
    } br_kind_e;

endpackage

//--- hw/core_ctrl_if.sv
`include "core_defs.svh"

interface core_ctrl_if;
    import core_pkg::*;

    logic [`REG_ADDR_W-1:0] rs1_addr;
    logic [`REG_ADDR_W-1:0] rs2_addr;
    logic [`REG_ADDR_W-1:0] rd_addr;
    logic [`XLEN-1:0]       imm;      // already sign extended
    alu_op_e                alu_op;
    logic                   op1_pc;   // alu a from pc instead of rs1
    logic                   op2_imm;  // alu b from imm instead of rs2
    wb_sel_e                wb_sel;
    logic                   reg_we;
    logic                   is_load;
    logic                   is_store;
    br_kind_e               br_kind;

    modport dec (output rs1_addr, rs2_addr, rd_addr, imm, alu_op, op1_pc, op2_imm,
                        wb_sel, reg_we, is_load, is_store, br_kind);
    modport dp  (input  rs1_addr, rs2_addr, rd_addr, imm, alu_op, op1_pc, op2_imm,
                        wb_sel, reg_we, is_load, is_store, br_kind);
    modport seq (input  is_load, is_store);  // fsm only needs mem kind
endinterface

//--- hw/core_fsm.sv
module core_fsm (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     inst_busy_i,
    input  logic     data_busy_i,
    core_ctrl_if.seq ctrl,
    output logic     inst_mem_read_o,
    output logic     data_mem_read_o,
    output logic     data_mem_write_o,
    output logic     ir_load_o,
    output logic     ex_en_o,
    output logic     mem_done_o,
    output logic     wb_en_o,
    output logic     pc_en_o
);
    localparam logic [2:0] st_fetch  = 3'd0;
    localparam logic [2:0] st_decode = 3'd1;
    localparam logic [2:0] st_exec   = 3'd2;
    localparam logic [2:0] st_mem    = 3'd3;
    localparam logic [2:0] st_wb     = 3'd4;

    logic [2:0] state_q;
    logic [2:0] state_d;
    logic       inst_rd_q;   // strobes come straight from flops
    logic       data_rd_q;
    logic       data_wr_q;

    // a transfer ends on the edge with strobe high and busy low
    assign ir_load_o  = (state_q == st_fetch) && inst_rd_q && !inst_busy_i;
    assign mem_done_o = (state_q == st_mem) && (data_rd_q || data_wr_q) && !data_busy_i;
    assign ex_en_o    = (state_q == st_exec);
    assign wb_en_o    = (state_q == st_wb);
    assign pc_en_o    = (state_q == st_wb);   // pc moves with the reg write

    assign inst_mem_read_o  = inst_rd_q;
    assign data_mem_read_o  = data_rd_q;
    assign data_mem_write_o = data_wr_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_fetch: begin
                if (ir_load_o) begin
                    state_d = st_decode;
                end
            end
            st_decode: state_d = st_exec;   // control settles from new ir
            st_exec: begin
                // only lw / sw go through mem
                state_d = (ctrl.is_load || ctrl.is_store) ? st_mem : st_wb;
            end
            st_mem: begin
                if (mem_done_o) begin
                    state_d = st_wb;
                end
            end
            st_wb:   state_d = st_fetch;
            default: state_d = st_fetch;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q   <= st_fetch;
            inst_rd_q <= 1'b0;   // fetch strobe rises one edge after reset
            data_rd_q <= 1'b0;
            data_wr_q <= 1'b0;
        end else begin
            state_q   <= state_d;
            inst_rd_q <= (state_d == st_fetch);
            data_rd_q <= (state_d == st_mem) && ctrl.is_load;
            data_wr_q <= (state_d == st_mem) && ctrl.is_store;
        end
    end
endmodule

//--- hw/pc_counter.sv
`include "core_defs.svh"

module pc_counter (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             pc_en_i,
    input  logic             take_i,
    input  logic [`XLEN-1:0] target_i,
    output logic [`XLEN-1:0] pc_o,
    output logic [`XLEN-1:0] pc_plus4_o
);
    logic [`XLEN-1:0] pc_q;

    assign pc_o       = pc_q;
    assign pc_plus4_o = pc_q + `XLEN'd4;   // no compressed, always +4

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_q <= `RESET_PC;
        end else if (pc_en_i) begin
            // taken branch or jal loads the alu target
            pc_q <= take_i ? target_i : pc_plus4_o;
        end
    end
endmodule

//--- hw/decoder.sv
`include "core_defs.svh"

module decoder (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             ir_load_i,
    input  logic [`XLEN-1:0] instr_i,
    core_ctrl_if.dec         ctrl
);
    import core_pkg::*;

    instr_u     ir_q;
    logic [6:0] opcode;
    logic [2:0] funct3;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ir_q <= '0;   // opcode 0 decodes as a bubble
        end else if (ir_load_i) begin
            ir_q <= instr_i;
        end
    end

    assign opcode = ir_q.r_fmt.opcode;   // same position in every format
    assign funct3 = ir_q.r_fmt.funct3;

    always_comb begin
        // safe defaults, no write, no mem, no branch
        ctrl.rs1_addr = ir_q.r_fmt.rs1;
        ctrl.rs2_addr = ir_q.r_fmt.rs2;
        ctrl.rd_addr  = ir_q.r_fmt.rd;
        ctrl.imm      = '0;
        ctrl.alu_op   = alu_add;
        ctrl.op1_pc   = 1'b0;
        ctrl.op2_imm  = 1'b0;
        ctrl.wb_sel   = wb_alu;
        ctrl.reg_we   = 1'b0;
        ctrl.is_load  = 1'b0;
        ctrl.is_store = 1'b0;
        ctrl.br_kind  = br_none;
        case (opcode)
            `OPC_OP: begin
                ctrl.reg_we = 1'b1;
                case (funct3)
                    `F3_ADD: ctrl.alu_op = ir_q.r_fmt.funct7[5] ? alu_sub : alu_add;
                    `F3_SLT: ctrl.alu_op = alu_slt;
                    `F3_XOR: ctrl.alu_op = alu_xor;
                    `F3_OR:  ctrl.alu_op = alu_or;
                    `F3_AND: ctrl.alu_op = alu_and;
                    default: ctrl.reg_we = 1'b0;   // shifts, sltu not in subset
                endcase
            end
            `OPC_OP_IMM: begin
                ctrl.imm     = {{(`XLEN-12){ir_q.i_fmt.imm[11]}}, ir_q.i_fmt.imm};
                ctrl.op2_imm = 1'b1;
                ctrl.reg_we  = 1'b1;
                case (funct3)
                    `F3_ADD: ctrl.alu_op = alu_add;
                    `F3_XOR: ctrl.alu_op = alu_xor;
                    `F3_OR:  ctrl.alu_op = alu_or;
                    `F3_AND: ctrl.alu_op = alu_and;
                    default: ctrl.reg_we = 1'b0;
                endcase
            end
            `OPC_LUI: begin
                ctrl.rs1_addr = '0;   // u format has no rs1
                ctrl.imm      = {ir_q.u_fmt.imm, 12'b0};
                ctrl.op2_imm  = 1'b1;
                ctrl.alu_op   = alu_pass_b;
                ctrl.reg_we   = 1'b1;
            end
            `OPC_LOAD: begin
                ctrl.imm     = {{(`XLEN-12){ir_q.i_fmt.imm[11]}}, ir_q.i_fmt.imm};
                ctrl.op2_imm = 1'b1;   // addr = rs1 + imm
                ctrl.wb_sel  = wb_load;
                ctrl.reg_we  = (funct3 == `F3_WORD);
                ctrl.is_load = (funct3 == `F3_WORD);   // lw only
            end
            `OPC_STORE: begin
                ctrl.imm      = {{(`XLEN-12){ir_q.s_fmt.imm_hi[6]}},
                                 ir_q.s_fmt.imm_hi, ir_q.s_fmt.imm_lo};
                ctrl.op2_imm  = 1'b1;
                ctrl.is_store = (funct3 == `F3_WORD);
            end
            `OPC_BRANCH: begin
                ctrl.imm     = {{(`XLEN-12){ir_q.b_fmt.imm12}}, ir_q.b_fmt.imm11,
                                ir_q.b_fmt.imm10_5, ir_q.b_fmt.imm4_1, 1'b0};
                ctrl.op1_pc  = 1'b1;   // alu makes pc + offset
                ctrl.op2_imm = 1'b1;
                if (funct3 == `F3_BEQ) begin
                    ctrl.br_kind = br_beq;
                end else if (funct3 == `F3_BNE) begin
                    ctrl.br_kind = br_bne;
                end
            end
            `OPC_JAL: begin
                ctrl.rs1_addr = '0;
                ctrl.imm      = {{(`XLEN-20){ir_q.j_fmt.imm20}}, ir_q.j_fmt.imm19_12,
                                 ir_q.j_fmt.imm11, ir_q.j_fmt.imm10_1, 1'b0};
                ctrl.op1_pc   = 1'b1;
                ctrl.op2_imm  = 1'b1;
                ctrl.wb_sel   = wb_pc_plus4;   // link value
                ctrl.reg_we   = 1'b1;
                ctrl.br_kind  = br_jal;
            end
            default: ;   // unknown opcode stays a bubble
        endcase
    end
endmodule

//--- hw/datapath.sv
`include "core_defs.svh"

module datapath (
    input  logic             clk_i,
    input  logic             rst_n_i,
    core_ctrl_if.dp          ctrl,
    input  logic             ex_en_i,
    input  logic             mem_done_i,
    input  logic             wb_en_i,
    input  logic [`XLEN-1:0] pc_i,
    input  logic [`XLEN-1:0] pc_plus4_i,
    input  logic [`XLEN-1:0] load_data_i,
    output logic             take_o,
    output logic [`XLEN-1:0] target_o,
    output logic [`XLEN-1:0] addr_o,
    output logic [`XLEN-1:0] wdata_o
);
    import core_pkg::*;

    logic [`XLEN-1:0] rf_q [2**`REG_ADDR_W];
    logic [`XLEN-1:0] rs1_val;
    logic [`XLEN-1:0] rs2_val;
    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] alu_y;
    logic [`XLEN-1:0] alu_res_q;   // held from exec to wb
    logic [`XLEN-1:0] load_q;
    logic [`XLEN-1:0] wb_data;

    // x0 hardwired to zero on read
    assign rs1_val = (ctrl.rs1_addr == '0) ? '0 : rf_q[ctrl.rs1_addr];
    assign rs2_val = (ctrl.rs2_addr == '0) ? '0 : rf_q[ctrl.rs2_addr];

    assign op_a = ctrl.op1_pc  ? pc_i     : rs1_val;
    assign op_b = ctrl.op2_imm ? ctrl.imm : rs2_val;

    always_comb begin
        case (ctrl.alu_op)
            alu_add:    alu_y = op_a + op_b;
            alu_sub:    alu_y = op_a - op_b;
            alu_and:    alu_y = op_a & op_b;
            alu_or:     alu_y = op_a | op_b;
            alu_xor:    alu_y = op_a ^ op_b;
            alu_slt:    alu_y = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            alu_pass_b: alu_y = op_b;   // lui
            default:    alu_y = op_a + op_b;
        endcase
    end

    // branch compare on raw register values, alu is busy with the target
    always_comb begin
        case (ctrl.br_kind)
            br_beq:  take_o = (rs1_val == rs2_val);
            br_bne:  take_o = (rs1_val != rs2_val);
            br_jal:  take_o = 1'b1;
            default: take_o = 1'b0;
        endcase
    end

    assign target_o = alu_res_q;
    assign addr_o   = alu_res_q;   // lw / sw effective address
    assign wdata_o  = rs2_val;     // stable while ir is held

    always_comb begin
        case (ctrl.wb_sel)
            wb_load:     wb_data = load_q;
            wb_pc_plus4: wb_data = pc_plus4_i;   // pc still old at wb
            default:     wb_data = alu_res_q;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            alu_res_q <= '0;   // data address known from reset
        end else if (ex_en_i) begin
            alu_res_q <= alu_y;
        end
    end

    always_ff @(posedge clk_i) begin
        if (mem_done_i) begin
            load_q <= load_data_i;   // also fires on sw, harmless
        end
        if (wb_en_i && ctrl.reg_we && (ctrl.rd_addr != '0)) begin
            rf_q[ctrl.rd_addr] <= wb_data;
        end
    end
endmodule

//--- hw/rv_core.sv
`include "core_defs.svh"

module rv_core (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic [`XLEN-1:0] instr_mem_read_i,
    input  logic             inst_busy_i,
    input  logic [`XLEN-1:0] data_mem_read_i,
    input  logic             data_busy_i,
    output logic             inst_mem_read_o,
    output logic [`XLEN-1:0] instr_addr_o,
    output logic             data_mem_read_o,
    output logic             data_mem_write_o,
    output logic [`XLEN-1:0] data_addr_o,
    output logic [`XLEN-1:0] data_mem_w_data_o
);
    logic             ir_load;
    logic             ex_en;
    logic             mem_done;
    logic             wb_en;
    logic             pc_en;
    logic             take;
    logic [`XLEN-1:0] target;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] pc_plus4;

    core_ctrl_if ctrl_if ();   // decoded control bundle

    assign instr_addr_o = pc;   // fetch address is the pc itself

    core_fsm u_fsm (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .inst_busy_i      (inst_busy_i),
        .data_busy_i      (data_busy_i),
        .ctrl             (ctrl_if.seq),
        .inst_mem_read_o  (inst_mem_read_o),
        .data_mem_read_o  (data_mem_read_o),
        .data_mem_write_o (data_mem_write_o),
        .ir_load_o        (ir_load),
        .ex_en_o          (ex_en),
        .mem_done_o       (mem_done),
        .wb_en_o          (wb_en),
        .pc_en_o          (pc_en)
    );

    pc_counter u_pc (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .pc_en_i    (pc_en),
        .take_i     (take),
        .target_i   (target),
        .pc_o       (pc),
        .pc_plus4_o (pc_plus4)
    );

    decoder u_dec (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .ir_load_i (ir_load),
        .instr_i   (instr_mem_read_i),   // sampled on the fetch completion edge
        .ctrl      (ctrl_if.dec)
    );

    datapath u_dp (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .ctrl        (ctrl_if.dp),
        .ex_en_i     (ex_en),
        .mem_done_i  (mem_done),
        .wb_en_i     (wb_en),
        .pc_i        (pc),
        .pc_plus4_i  (pc_plus4),
        .load_data_i (data_mem_read_i),
        .take_o      (take),
        .target_o    (target),
        .addr_o      (data_addr_o),
        .wdata_o     (data_mem_w_data_o)
    );
endmodule

//--- dv/clk_gen.sv
module clk_gen (
    output logic clk_o,
    output logic rst_n_o
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;   // 8 ns period
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (8) @(posedge clk_o);
        #1 rst_n_o = 1'b1;   // released just after the 8th edge
    end
endmodule

//--- dv/rv_core_checker.sv
`include "core_defs.svh"

module rv_core_checker (
    input logic             clk_i,
    input logic             rst_n_i,
    input logic             inst_rd_i,
    input logic             inst_busy_i,
    input logic [`XLEN-1:0] inst_addr_i,
    input logic             data_rd_i,
    input logic             data_wr_i,
    input logic             data_busy_i,
    input logic [`XLEN-1:0] data_addr_i,
    input logic [`XLEN-1:0] data_wdata_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // fetch request frozen while imem is busy
    a_inst_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        inst_rd_i && inst_busy_i |=> inst_rd_i && $stable(inst_addr_i))
        else $error("fetch strobe or address changed while busy");

    a_read_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        data_rd_i && data_busy_i |=> data_rd_i && $stable(data_addr_i))
        else $error("data read strobe or address changed while busy");

    // store also keeps its write data
    a_write_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        data_wr_i && data_busy_i |=> data_wr_i && $stable(data_addr_i)
            && $stable(data_wdata_i))
        else $error("data write strobe, address or data changed while busy");

    a_rd_wr_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(data_rd_i && data_wr_i))
        else $error("data read and write strobes high together");

    a_reset_quiet: assert property (@(posedge clk_i)
        !rst_n_i |=> !inst_rd_i && !data_rd_i && !data_wr_i)
        else $error("memory strobe high after a reset edge");
endmodule

bind rv_core rv_core_checker i_checker (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .inst_rd_i    (inst_mem_read_o),
    .inst_busy_i  (inst_busy_i),
    .inst_addr_i  (instr_addr_o),
    .data_rd_i    (data_mem_read_o),
    .data_wr_i    (data_mem_write_o),
    .data_busy_i  (data_busy_i),
    .data_addr_i  (data_addr_o),
    .data_wdata_i (data_mem_w_data_o)
);

//--- dv/tb_rv_core.sv
`include "core_defs.svh"

module tb_rv_core;
    timeunit 1ns;
    timeprecision 1ps;

    typedef enum logic [2:0] {
        op_add, op_sub, op_and, op_or, op_xor, op_slt, op_lui
    } ref_op_e;

    localparam logic [11:0] load_addr = 12'h3c4;
    localparam logic [11:0] skip_addr = 12'h7f0;   // written only by a wrong branch

    logic             clk;
    logic             rst_n;
    logic [`XLEN-1:0] instr_data;
    logic             inst_busy;
    logic [`XLEN-1:0] data_rdata;
    logic             data_busy;
    logic             inst_rd;
    logic [`XLEN-1:0] instr_addr;
    logic             data_rd;
    logic             data_wr;
    logic [`XLEN-1:0] data_addr;
    logic [`XLEN-1:0] data_wdata;

    logic [31:0] imem [64];
    logic [31:0] exp_addr_q [$];
    logic [31:0] exp_data_q [$];
    logic [31:0] lfsr_state = 32'hc9b3;
    logic [31:0] st_addr;
    logic [5:0]  wr_idx;
    int          n_seen = 0;   // completed stores so far
    logic        inst_active;
    logic        data_active;
    logic [31:0] inst_left;
    logic [31:0] data_left;

    clk_gen u_clk (.clk_o(clk), .rst_n_o(rst_n));

    rv_core i_dut (
        .clk_i             (clk),
        .rst_n_i           (rst_n),
        .instr_mem_read_i  (instr_data),
        .inst_busy_i       (inst_busy),
        .data_mem_read_i   (data_rdata),
        .data_busy_i       (data_busy),
        .inst_mem_read_o   (inst_rd),
        .instr_addr_o      (instr_addr),
        .data_mem_read_o   (data_rd),
        .data_mem_write_o  (data_wr),
        .data_addr_o       (data_addr),
        .data_mem_w_data_o (data_wdata)
    );

    // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] draw(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            val = {val[30:0], fb};
        end
        return val;
    endfunction

    // rv32i result of one alu operation
    function automatic logic [31:0] expected_result(input ref_op_e op,
                                                    input logic [31:0] a,
                                                    input logic [31:0] b);
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return {b[19:0], 12'h000};   // lui takes imm20 in b
        endcase
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ 32'h6b3d_91c5;   // spread over every address bit
    endfunction

    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `OPC_OP};
    endfunction

    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_word(input logic [11:0] imm, input logic [4:0] rs2);
        return {imm[11:5], rs2, 5'd0, `F3_WORD, imm[4:0], `OPC_STORE};   // base x0
    endfunction

    function automatic logic [31:0] b_word(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OPC_BRANCH};
    endfunction

    function automatic logic [31:0] u_word(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, `OPC_LUI};
    endfunction

    function automatic logic [31:0] j_word(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OPC_JAL};
    endfunction

    task automatic stop_run();
        $display("Checks failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_eq(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic put_word(input logic [31:0] word);
        imem[wr_idx] = word;
        wr_idx = wr_idx + 6'd1;
    endtask

    task automatic store_expect(input logic [4:0] rs, input logic [31:0] val);
        put_word(s_word(st_addr[11:0], rs));
        exp_addr_q.push_back(st_addr);
        exp_data_q.push_back(val);
        st_addr = st_addr + 32'd4;
    endtask

    task automatic load_const(input logic [4:0] rd, input logic [31:0] val);
        logic [31:0] adj;
        adj = val + 32'h800;   // addi sign extends the low 12 bits
        put_word(u_word(adj[31:12], rd));
        put_word(i_word(val[11:0], rd, `F3_ADD, rd, `OPC_OP_IMM));
    endtask

    task automatic reg_op(input ref_op_e op, input logic [6:0] f7, input logic [2:0] f3,
                          input logic [31:0] a, input logic [31:0] b);
        put_word(r_word(f7, 5'd2, 5'd1, f3, 5'd3));
        store_expect(5'd3, expected_result(op, a, b));
    endtask

    task automatic imm_op(input ref_op_e op, input logic [2:0] f3, input logic [31:0] a);
        logic [31:0] r;
        r = draw(12);
        put_word(i_word(r[11:0], 5'd1, f3, 5'd3, `OPC_OP_IMM));
        store_expect(5'd3, expected_result(op, a, {{20{r[11]}}, r[11:0]}));
    endtask

    task automatic build_program();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic [31:0] jal_pc;
        imem    = '{default: '0};
        wr_idx  = '0;
        st_addr = 32'h100;
        a = draw(32);
        b = draw(32);
        load_const(5'd1, a);   // x1 = a
        load_const(5'd2, b);   // x2 = b
        reg_op(op_add, 7'h00, `F3_ADD, a, b);
        reg_op(op_sub, 7'h20, `F3_ADD, a, b);
        reg_op(op_and, 7'h00, `F3_AND, a, b);
        reg_op(op_or,  7'h00, `F3_OR,  a, b);
        reg_op(op_xor, 7'h00, `F3_XOR, a, b);
        reg_op(op_slt, 7'h00, `F3_SLT, a, b);
        imm_op(op_add, `F3_ADD, a);
        imm_op(op_and, `F3_AND, a);
        imm_op(op_or,  `F3_OR,  a);
        imm_op(op_xor, `F3_XOR, a);
        r = draw(20);
        put_word(u_word(r[19:0], 5'd3));
        store_expect(5'd3, expected_result(op_lui, 32'h0, r));
        // lw from the fill pattern and store it back
        put_word(i_word(load_addr, 5'd0, `F3_WORD, 5'd4, `OPC_LOAD));
        store_expect(5'd4, fill_word({20'h0, load_addr}));
        put_word(i_word(12'd7, 5'd0, `F3_ADD, 5'd5, `OPC_OP_IMM));
        put_word(i_word(12'd7, 5'd0, `F3_ADD, 5'd6, `OPC_OP_IMM));
        put_word(i_word(12'd9, 5'd0, `F3_ADD, 5'd7, `OPC_OP_IMM));
        put_word(b_word(13'd8, 5'd6, 5'd5, `F3_BEQ));   // taken
        put_word(s_word(skip_addr, 5'd1));
        store_expect(5'd6, 32'd7);
        put_word(b_word(13'd8, 5'd6, 5'd5, `F3_BNE));   // not taken
        store_expect(5'd5, 32'd7);
        put_word(b_word(13'd8, 5'd7, 5'd5, `F3_BNE));   // taken
        put_word(s_word(skip_addr, 5'd2));
        store_expect(5'd7, 32'd9);
        put_word(b_word(13'd8, 5'd7, 5'd5, `F3_BEQ));   // not taken
        store_expect(5'd5, 32'd7);
        jal_pc = {24'h0, wr_idx, 2'b00};
        put_word(j_word(21'd8, 5'd8));
        put_word(s_word(skip_addr, 5'd1));
        store_expect(5'd8, jal_pc + 32'd4);   // link value
        put_word(j_word(21'd0, 5'd0));        // park in a self loop
    endtask

    // one memory port with 0..3 random busy cycles per transfer
    task automatic step_port(input logic strobe, inout logic active,
                             inout logic [31:0] left, inout logic busy);
        if (active && !busy) begin
            active = 1'b0;   // completed on this edge
        end
        if (!active && strobe) begin
            active = 1'b1;
            left   = draw(2);
        end else if (active) begin
            left = left - 32'd1;
        end
        busy = active && (left != 32'd0);
    endtask

    task automatic drive_memories();
        forever begin
            @(posedge clk);
            #1;
            step_port(inst_rd, inst_active, inst_left, inst_busy);
            step_port(data_rd || data_wr, data_active, data_left, data_busy);
            instr_data = imem[instr_addr[7:2]];
            data_rdata = fill_word(data_addr);
        end
    endtask

    // bus settled at mid cycle and the write completes on the next edge
    always @(negedge clk) begin
        if (rst_n && data_wr && !data_busy) begin
            if (n_seen >= exp_addr_q.size()) begin
                $display("unexpected data write to address 0x%h", data_addr);
                stop_run();
            end else begin
                check_eq("data_addr_o", data_addr, exp_addr_q[n_seen]);
                check_eq("data_mem_w_data_o", data_wdata, exp_data_q[n_seen]);
                n_seen <= n_seen + 1;
            end
        end
    end

    initial begin : main
        int cyc;
        instr_data  = '0;
        inst_busy   = 1'b0;
        data_rdata  = '0;
        data_busy   = 1'b0;
        inst_active = 1'b0;
        data_active = 1'b0;
        inst_left   = '0;
        data_left   = '0;
        build_program();
        fork
            drive_memories();
        join_none

        cyc = 0;
        while (rst_n !== 1'b1) begin
            @(negedge clk);
            cyc++;
            if (cyc > 20) begin
                $display("reset was never released");
                stop_run();
            end
        end
        check_eq("inst_mem_read_o", 32'(inst_rd), 32'd0);
        check_eq("data_mem_read_o", 32'(data_rd), 32'd0);
        check_eq("data_mem_write_o", 32'(data_wr), 32'd0);

        cyc = 0;
        while (!inst_rd) begin
            @(negedge clk);
            cyc++;
            if (cyc > 4) begin
                $display("first fetch strobe never rose after reset");
                stop_run();
            end
        end
        check_eq("cycles to first inst_mem_read_o", 32'(cyc), 32'd1);
        check_eq("instr_addr_o", instr_addr, `RESET_PC);

        cyc = 0;
        while (n_seen < exp_addr_q.size()) begin
            @(posedge clk);
            cyc++;
            if (cyc > 4000) begin
                $display("program did not complete its stores in time");
                stop_run();
            end
        end
        repeat (20) @(posedge clk);   // a stray store would show up here
        $display("All checks passed");
        $finish;
    end
endmodule

//--- rv_core.f
+incdir+hw
hw/core_pkg.sv
hw/core_ctrl_if.sv
hw/core_fsm.sv
hw/pc_counter.sv
hw/decoder.sv
hw/datapath.sv
hw/rv_core.sv
dv/clk_gen.sv
dv/rv_core_checker.sv
dv/tb_rv_core.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_rv_core
FILELIST := rv_core.f
LOG      := sim.log
FAIL_MSG := Checks failed
PASS_MSG := All checks passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build $(TOP) with $(SIM), run it and search $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "test FAILED"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf obj_dir $(LOG)
